// File: build.f
+incdir+verilog
verilog/crypt_pkg.sv
verilog/crypt_regfile.sv
verilog/crypt_fsm.sv
verilog/block_source.sv
verilog/block_fifo.sv
verilog/cipher_writer.sv
verilog/crypt_top.sv
bench/crypt_tb.sv

// File: Makefile
# Verilator build and run of the block encryption testbench

all: run

obj_dir/Vcrypt_tb: build.f verilog/*.sv verilog/*.svh bench/*.sv
	verilator --binary --timing --assert -f build.f --top-module crypt_tb -o Vcrypt_tb

run: obj_dir/Vcrypt_tb
	./obj_dir/Vcrypt_tb | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module crypt_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: bench/crypt_tb.sv
`default_nettype none

`include "crypt_defs.svh"

module crypt_tb;

  localparam int             MAX_WORDS   = 64;
  localparam int             RUN_TIMEOUT = 2000;
  localparam logic [31:0]    LCG_SEED    = 32'heae7_6c4c;
  localparam logic [63:0]    KEY_A       = 64'h0f1e_2d3c_4b5a_6978;
  localparam logic [63:0]    KEY_B       = 64'h9a8b_7c6d_5e4f_3021;

  logic                      clk;
  logic                      reset_n;
  logic                      cfg_we_i;
  logic [`CRYPT_REG_AW-1:0]  cfg_addr_i;
  logic [`CRYPT_DATA_W-1:0]  cfg_wdata_i;
  logic [`CRYPT_DATA_W-1:0]  cfg_rdata_o;
  logic                      mem_rd_o;
  logic [`CRYPT_ADDR_W-1:0]  mem_raddr_o;
  logic [`CRYPT_DATA_W-1:0]  mem_rdata_i = '0;
  logic                      mem_wr_o;
  logic [`CRYPT_ADDR_W-1:0]  mem_waddr_o;
  logic [`CRYPT_DATA_W-1:0]  mem_wdata_o;
  logic                      done_o;

  logic [`CRYPT_DATA_W-1:0]  mem [0:65535];
  logic [`CRYPT_DATA_W-1:0]  exp_words [0:MAX_WORDS-1];

  // Current run as programmed by the host
  int   run_src;
  int   run_dst;
  int   run_blocks;
  int   rd_count;
  int   wr_count;
  int   done_count;
  logic clear_counts = 1'b0;
  logic idle_check = 1'b0;
  logic done_d1 = 1'b0;

  crypt_top UUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .mem_rd_o    (mem_rd_o),
    .mem_raddr_o (mem_raddr_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_wr_o    (mem_wr_o),
    .mem_waddr_o (mem_waddr_o),
    .mem_wdata_o (mem_wdata_o),
    .done_o      (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reference cipher, returns {left, right} after all rounds
  function automatic logic [63:0] feistel_encrypt(input logic [31:0] lo_word,
                                                  input logic [31:0] hi_word,
                                                  input logic [63:0] key);
    logic [31:0] l;
    logic [31:0] r;
    logic [31:0] k;
    logic [31:0] s;
    logic [31:0] t;
    int          i;
    l = hi_word;
    r = lo_word;
    for (i = 0; i < `CRYPT_ROUNDS; i++) begin
      k = (i % 2 == 1) ? key[63:32] : key[31:0];
      k = k ^ 32'(i);
      s = r + k;
      t = l ^ {s[26:0], s[31:27]};
      l = r;
      r = t;
    end
    return {l, r};
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Memory model, refilled from the LCG while reset is low
  always @(posedge clk) begin
    logic [31:0] seed;
    int          a;
    if (!reset_n) begin
      seed = LCG_SEED;
      for (a = 0; a < 65536; a++) begin
        mem[a] <= seed;
        seed = lcg_next(seed);
      end
      mem_rdata_i <= '0;
    end else begin
      if (mem_rd_o) begin
        mem_rdata_i <= mem[mem_raddr_o];
      end
      if (mem_wr_o) begin
        mem[mem_waddr_o] <= mem_wdata_o;
      end
    end
  end

  // Traffic counters for the run in progress
  always @(posedge clk) begin
    done_d1 <= done_o;
    if (clear_counts) begin
      rd_count   <= 0;
      wr_count   <= 0;
      done_count <= 0;
    end else begin
      if (mem_rd_o) begin
        rd_count <= rd_count + 1;
      end
      if (mem_wr_o) begin
        wr_count <= wr_count + 1;
      end
      if (done_o) begin
        done_count <= done_count + 1;
      end
    end
  end

  idle_outputs: assert property (@(posedge clk)
    idle_check |-> !mem_rd_o && !mem_wr_o && !done_o)
    else fail_now($sformatf("MISMATCH at %0t: strobe or done_o high after reset", $time));

  idle_status: assert property (@(posedge clk) idle_check |-> cfg_rdata_o == '0)
    else fail_now($sformatf("MISMATCH at %0t: STATUS not zero after reset", $time));

  read_addr: assert property (@(posedge clk) disable iff (!reset_n)
    mem_rd_o |-> rd_count < 2 * run_blocks &&
                 mem_raddr_o == `CRYPT_ADDR_W'(run_src + rd_count))
    else fail_now($sformatf("MISMATCH at %0t: unexpected read of %h", $time, mem_raddr_o));

  // A new block is only opened if it fits the FIFO plus the block in the writer
  read_window: assert property (@(posedge clk) disable iff (!reset_n)
    (mem_rd_o && !rd_count[0]) |-> rd_count / 2 + 1 <= wr_count / 2 + `CRYPT_FIFO_DEPTH + 1)
    else fail_now($sformatf("MISMATCH at %0t: reads ran ahead of FIFO space", $time));

  write_addr: assert property (@(posedge clk) disable iff (!reset_n)
    mem_wr_o |-> wr_count < 2 * run_blocks &&
                 mem_waddr_o == `CRYPT_ADDR_W'(run_dst + wr_count))
    else fail_now($sformatf("MISMATCH at %0t: unexpected write to %h", $time, mem_waddr_o));

  write_data: assert property (@(posedge clk) disable iff (!reset_n)
    mem_wr_o |-> mem_wdata_o == exp_words[wr_count])
    else fail_now($sformatf("MISMATCH at %0t: wrote %h to %h, expected %h", $time,
                            mem_wdata_o, mem_waddr_o, exp_words[wr_count]));

  done_traffic: assert property (@(posedge clk) disable iff (!reset_n)
    done_o |-> rd_count == 2 * run_blocks && wr_count == 2 * run_blocks)
    else fail_now($sformatf("MISMATCH at %0t: done_o after %0d reads and %0d writes",
                            $time, rd_count, wr_count));

  done_single: assert property (@(posedge clk) disable iff (!reset_n)
    done_o |-> done_count == 0)
    else fail_now($sformatf("MISMATCH at %0t: second done_o pulse in one run", $time));

  status_done: assert property (@(posedge clk) disable iff (!reset_n)
    (done_d1 && !cfg_we_i) |-> cfg_rdata_o[1:0] == 2'b10)
    else fail_now($sformatf("MISMATCH at %0t: STATUS done bit not set", $time));

  // Busy always means the sticky done bit was dropped by the start
  status_clear: assert property (@(posedge clk) disable iff (!reset_n)
    (!cfg_we_i && cfg_rdata_o[0]) |-> !cfg_rdata_o[1])
    else fail_now($sformatf("MISMATCH at %0t: STATUS done still set while busy", $time));

  task automatic reg_write(input logic [`CRYPT_REG_AW-1:0] addr, input logic [31:0] data,
                           input logic arm);
    @(posedge clk);
    cfg_we_i     <= 1'b1;
    cfg_addr_i   <= addr;
    cfg_wdata_i  <= data;
    clear_counts <= arm;
    @(posedge clk);
    cfg_we_i     <= 1'b0;
    cfg_addr_i   <= `CRYPT_REG_STATUS;
    cfg_wdata_i  <= '0;
    clear_counts <= 1'b0;
  endtask

  task automatic start_run(input int src, input int dst, input int blocks,
                           input logic [63:0] key);
    logic [63:0] ct;
    int          b;
    run_src    = src;
    run_dst    = dst;
    run_blocks = blocks;
    for (b = 0; b < blocks; b++) begin
      ct = feistel_encrypt(mem[src + 2 * b], mem[src + 2 * b + 1], key);
      exp_words[2 * b]     = ct[31:0];
      exp_words[2 * b + 1] = ct[63:32];
    end
    reg_write(`CRYPT_REG_SRC, 32'(src), 1'b0);
    reg_write(`CRYPT_REG_DST, 32'(dst), 1'b0);
    reg_write(`CRYPT_REG_CNT, 32'(blocks), 1'b0);
    reg_write(`CRYPT_REG_KEY_LO, key[31:0], 1'b0);
    reg_write(`CRYPT_REG_KEY_HI, key[63:32], 1'b0);
    reg_write(`CRYPT_REG_CMD, 32'd1, 1'b1);
  endtask

  task automatic wait_done(input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    // done_o looked at mid-cycle, away from the clock edge
    while (!seen && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      seen = done_o;
      cycles++;
    end
    if (!seen) begin
      fail_now($sformatf("Timed out waiting for done_o on the %s run", what));
    end else begin
      // Back on the edge that ends the done pulse
      @(posedge clk);
    end
  endtask

  initial begin
    reset_n     = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = `CRYPT_REG_STATUS;
    cfg_wdata_i = '0;
    repeat (5) @(posedge clk);
    reset_n    <= 1'b1;
    idle_check <= 1'b1;
    repeat (8) @(posedge clk);
    idle_check <= 1'b0;

    start_run(16'h0100, 16'h2000, 6, KEY_A);
    wait_done("six block");
    start_run(16'h0200, 16'h2100, 1, KEY_A);
    wait_done("single block");
    start_run(16'h0300, 16'h2200, 3, KEY_B);
    wait_done("second key");
    // Longer than the FIFO, so the source has to stall
    start_run(16'h0400, 16'h3000, 10, KEY_B);
    wait_done("long");
    start_run(16'h0500, 16'h3100, 0, KEY_A);
    wait_done("empty");

    // CMD written again in the middle of a run
    start_run(16'h0600, 16'h3200, 5, KEY_A);
    repeat (6) @(posedge clk);
    reg_write(`CRYPT_REG_CMD, 32'd1, 1'b0);
    wait_done("restarted");
    repeat (30) @(posedge clk);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/crypt_top.sv
`default_nettype none

`include "crypt_defs.svh"

module crypt_top (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire                       cfg_we_i,
  input  wire [`CRYPT_REG_AW-1:0]   cfg_addr_i,
  input  wire [`CRYPT_DATA_W-1:0]   cfg_wdata_i,
  output logic [`CRYPT_DATA_W-1:0]  cfg_rdata_o,
  output logic                      mem_rd_o,
  output logic [`CRYPT_ADDR_W-1:0]  mem_raddr_o,
  input  wire [`CRYPT_DATA_W-1:0]   mem_rdata_i,
  output logic                      mem_wr_o,
  output logic [`CRYPT_ADDR_W-1:0]  mem_waddr_o,
  output logic [`CRYPT_DATA_W-1:0]  mem_wdata_o,
  output logic                      done_o
);

  crypt_pkg::cfg_t            cfg;
  crypt_pkg::slave_flags_t    slave_flags;
  crypt_pkg::slave_ctrl_t     slave_ctrl;
  crypt_pkg::stream_ctrl_t    stream_ctrl;
  crypt_pkg::engine_ctrl_t    engine_ctrl;
  crypt_pkg::source_flags_t   source_flags;
  crypt_pkg::writer_flags_t   writer_flags;
  crypt_pkg::block_u          push_data;
  crypt_pkg::block_u          pop_data;
  logic                       busy;
  logic                       push;
  logic                       pop;
  logic                       fifo_empty;
  logic                       fifo_full;
  logic [$clog2(`CRYPT_FIFO_DEPTH+1)-1:0] fifo_count;

  crypt_regfile u_regfile (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_rdata_o   (cfg_rdata_o),
    .busy_i        (busy),
    .slave_ctrl_i  (slave_ctrl),
    .slave_flags_o (slave_flags),
    .cfg_o         (cfg)
  );

  crypt_fsm u_fsm (
    .clk            (clk),
    .reset_n        (reset_n),
    .slave_flags_i  (slave_flags),
    .source_flags_i (source_flags),
    .writer_flags_i (writer_flags),
    .fifo_empty_i   (fifo_empty),
    .stream_ctrl_o  (stream_ctrl),
    .engine_ctrl_o  (engine_ctrl),
    .slave_ctrl_o   (slave_ctrl),
    .busy_o         (busy)
  );

  block_source u_source (
    .clk           (clk),
    .reset_n       (reset_n),
    .engine_ctrl_i (engine_ctrl),
    .stream_ctrl_i (stream_ctrl),
    .cfg_i         (cfg),
    .mem_rd_o      (mem_rd_o),
    .mem_raddr_o   (mem_raddr_o),
    .mem_rdata_i   (mem_rdata_i),
    .fifo_full_i   (fifo_full),
    .fifo_count_i  (fifo_count),
    .push_o        (push),
    .push_data_o   (push_data),
    .flags_o       (source_flags)
  );

  block_fifo u_fifo (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (engine_ctrl.clear),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full),
    .count_o     (fifo_count)
  );

  cipher_writer u_writer (
    .clk           (clk),
    .reset_n       (reset_n),
    .engine_ctrl_i (engine_ctrl),
    .stream_ctrl_i (stream_ctrl),
    .cfg_i         (cfg),
    .fifo_empty_i  (fifo_empty),
    .pop_o         (pop),
    .pop_data_i    (pop_data),
    .mem_wr_o      (mem_wr_o),
    .mem_waddr_o   (mem_waddr_o),
    .mem_wdata_o   (mem_wdata_o),
    .flags_o       (writer_flags)
  );

  assign done_o = slave_ctrl.done;

endmodule

`default_nettype wire

// File: verilog/cipher_writer.sv
`default_nettype none

`include "crypt_defs.svh"

module cipher_writer (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire crypt_pkg::engine_ctrl_t engine_ctrl_i,
  input  wire crypt_pkg::stream_ctrl_t stream_ctrl_i,
  input  wire crypt_pkg::cfg_t         cfg_i,
  input  wire                          fifo_empty_i,
  output logic                         pop_o,
  input  wire crypt_pkg::block_u       pop_data_i,
  output logic                         mem_wr_o,
  output logic [`CRYPT_ADDR_W-1:0]     mem_waddr_o,
  output logic [`CRYPT_DATA_W-1:0]     mem_wdata_o,
  output crypt_pkg::writer_flags_t     flags_o
);

  localparam int W  = `CRYPT_DATA_W;
  localparam int SW = $clog2(`CRYPT_ROUNDS + 2);
  localparam logic [SW-1:0] WR0 = SW'(`CRYPT_ROUNDS);
  localparam logic [SW-1:0] WR1 = SW'(`CRYPT_ROUNDS + 1);

  logic                     active_q;
  logic                     running_q;
  logic                     done_q;
  logic [SW-1:0]            step_q;
  logic [`CRYPT_CNT_W-1:0]  blocks_left_q;
  logic [`CRYPT_ADDR_W-1:0] dst_q;
  logic [2*W-1:0]           key_q;
  crypt_pkg::block_u        blk_q;
  crypt_pkg::block_u        blk_next;
  logic [W-1:0]             subkey;
  logic [W-1:0]             sum;
  logic                     last_wr;

  assign last_wr = running_q && (step_q == WR1);

  // Next block may come out during the last write of the current one
  assign pop_o = active_q && !fifo_empty_i &&
                 (!running_q || (last_wr && blocks_left_q != `CRYPT_CNT_W'(1)));

  // One Feistel round, step_q is the round index
  always_comb begin
    subkey = step_q[0] ? key_q[2*W-1:W] : key_q[W-1:0];
    subkey = subkey ^ W'(step_q);
    sum    = blk_q.half.right + subkey;
    blk_next.half.left  = blk_q.half.right;
    blk_next.half.right = blk_q.half.left ^ ((sum << 5) | (sum >> (W - 5)));
  end

  assign mem_wr_o     = running_q && (step_q >= WR0);
  assign mem_waddr_o  = dst_q + `CRYPT_ADDR_W'(last_wr);
  assign mem_wdata_o  = last_wr ? blk_q.word[1] : blk_q.word[0];
  assign flags_o.done = done_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q      <= 1'b0;
      running_q     <= 1'b0;
      done_q        <= 1'b0;
      step_q        <= '0;
      blocks_left_q <= '0;
      dst_q         <= '0;
      key_q         <= '0;
    end else if (engine_ctrl_i.clear) begin
      active_q  <= 1'b0;
      running_q <= 1'b0;
      done_q    <= 1'b0;
    end else if (stream_ctrl_i.start) begin
      active_q      <= (cfg_i.blk_count != '0);
      done_q        <= (cfg_i.blk_count == '0);
      blocks_left_q <= cfg_i.blk_count;
      dst_q         <= cfg_i.dst_base;
      key_q         <= cfg_i.key;
    end else begin
      if (pop_o) begin
        running_q <= 1'b1;
        step_q    <= '0;
      end else if (running_q) begin
        running_q <= !last_wr;
        step_q    <= step_q + 1'b1;
      end
      if (last_wr) begin
        blocks_left_q <= blocks_left_q - 1'b1;
        dst_q         <= dst_q + `CRYPT_ADDR_W'(2);
        if (blocks_left_q == `CRYPT_CNT_W'(1)) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  // Block register, loaded on pop then updated once per round
  always_ff @(posedge clk) begin
    if (pop_o) begin
      blk_q <= pop_data_i;
    end else if (running_q && (step_q < WR0)) begin
      blk_q <= blk_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/block_fifo.sv
`default_nettype none

`include "crypt_defs.svh"

module block_fifo (
  input  wire                                    clk,
  input  wire                                    reset_n,
  input  wire                                    clear_i,
  input  wire                                    push_i,
  input  wire crypt_pkg::block_u                 push_data_i,
  input  wire                                    pop_i,
  output crypt_pkg::block_u                      pop_data_o,
  output logic                                   empty_o,
  output logic                                   full_o,
  output logic [$clog2(`CRYPT_FIFO_DEPTH+1)-1:0] count_o
);

  localparam int PW = $clog2(`CRYPT_FIFO_DEPTH);
  localparam int CW = $clog2(`CRYPT_FIFO_DEPTH + 1);

  crypt_pkg::block_u mem_q [`CRYPT_FIFO_DEPTH];
  logic [PW-1:0]     wr_ptr_q;
  logic [PW-1:0]     rd_ptr_q;
  logic [CW-1:0]     count_q;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    return (ptr == PW'(`CRYPT_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CW'(push_i) - CW'(pop_i);
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head entry is visible before the pop
  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == CW'(`CRYPT_FIFO_DEPTH));
  assign count_o    = count_q;

  no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
    push_i |-> !full_o)
    else $error("block source pushed into a full FIFO");

  no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
    pop_i |-> !empty_o)
    else $error("cipher writer popped an empty FIFO");

endmodule

`default_nettype wire

// File: verilog/block_source.sv
`default_nettype none

`include "crypt_defs.svh"

module block_source (
  input  wire                                    clk,
  input  wire                                    reset_n,
  input  wire crypt_pkg::engine_ctrl_t           engine_ctrl_i,
  input  wire crypt_pkg::stream_ctrl_t           stream_ctrl_i,
  input  wire crypt_pkg::cfg_t                   cfg_i,
  output logic                                   mem_rd_o,
  output logic [`CRYPT_ADDR_W-1:0]               mem_raddr_o,
  input  wire [`CRYPT_DATA_W-1:0]                mem_rdata_i,
  input  wire                                    fifo_full_i,
  input  wire [$clog2(`CRYPT_FIFO_DEPTH+1)-1:0]  fifo_count_i,
  output logic                                   push_o,
  output crypt_pkg::block_u                      push_data_o,
  output crypt_pkg::source_flags_t               flags_o
);

  localparam int CW = $clog2(`CRYPT_FIFO_DEPTH + 1);

  logic                     active_q;
  logic                     done_q;
  logic [`CRYPT_ADDR_W-1:0] rd_addr_q;
  logic [`CRYPT_CNT_W:0]    words_left_q;
  logic [`CRYPT_CNT_W-1:0]  blocks_left_q;
  logic                     odd_q;
  logic                     rd_valid_q;
  logic                     rd_odd_q;
  logic [1:0]               flight_q;
  logic [`CRYPT_DATA_W-1:0] lo_q;
  logic [CW:0]              committed;
  logic                     can_open;

  // FIFO entries plus blocks opened by a read but not pushed yet
  assign committed = {1'b0, fifo_count_i} + (CW+1)'(flight_q);
  assign can_open  = !fifo_full_i && (committed < (CW+1)'(`CRYPT_FIFO_DEPTH));

  // Word 1 always follows its word 0, only a new block waits for space
  assign mem_rd_o    = active_q && (words_left_q != '0) && (odd_q || can_open);
  assign mem_raddr_o = rd_addr_q;

  assign push_o       = rd_valid_q && rd_odd_q;
  assign flags_o.done = done_q;

  always_comb begin
    push_data_o.word[0] = lo_q;
    push_data_o.word[1] = mem_rdata_i;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q      <= 1'b0;
      done_q        <= 1'b0;
      rd_addr_q     <= '0;
      words_left_q  <= '0;
      blocks_left_q <= '0;
      odd_q         <= 1'b0;
      rd_valid_q    <= 1'b0;
      rd_odd_q      <= 1'b0;
      flight_q      <= '0;
    end else if (engine_ctrl_i.clear) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      odd_q      <= 1'b0;
      rd_valid_q <= 1'b0;
      flight_q   <= '0;
    end else begin
      rd_valid_q <= mem_rd_o;
      rd_odd_q   <= odd_q;
      flight_q   <= flight_q + 2'(mem_rd_o && !odd_q) - 2'(push_o);
      if (stream_ctrl_i.start) begin
        // Empty run reports done straight away
        active_q      <= (cfg_i.blk_count != '0);
        done_q        <= (cfg_i.blk_count == '0);
        rd_addr_q     <= cfg_i.src_base;
        words_left_q  <= {cfg_i.blk_count, 1'b0};
        blocks_left_q <= cfg_i.blk_count;
        odd_q         <= 1'b0;
      end else begin
        if (mem_rd_o) begin
          rd_addr_q    <= rd_addr_q + 1'b1;
          words_left_q <= words_left_q - 1'b1;
          odd_q        <= !odd_q;
        end
        if (push_o) begin
          blocks_left_q <= blocks_left_q - 1'b1;
          if (blocks_left_q == `CRYPT_CNT_W'(1)) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
          end
        end
      end
    end
  end

  // Low word waits here for its partner
  always_ff @(posedge clk) begin
    if (rd_valid_q && !rd_odd_q) begin
      lo_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/crypt_fsm.sv
`default_nettype none

module crypt_fsm (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire crypt_pkg::slave_flags_t   slave_flags_i,
  input  wire crypt_pkg::source_flags_t  source_flags_i,
  input  wire crypt_pkg::writer_flags_t  writer_flags_i,
  input  wire                            fifo_empty_i,
  output crypt_pkg::stream_ctrl_t        stream_ctrl_o,
  output crypt_pkg::engine_ctrl_t        engine_ctrl_o,
  output crypt_pkg::slave_ctrl_t         slave_ctrl_o,
  output logic                           busy_o
);

  crypt_pkg::crypt_state_t state_q;
  crypt_pkg::crypt_state_t state_d;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= crypt_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      crypt_pkg::IDLE: begin
        if (slave_flags_i.start) begin
          state_d = crypt_pkg::STARTING;
        end
      end
      crypt_pkg::STARTING: begin
        state_d = crypt_pkg::WORKING;
      end
      crypt_pkg::WORKING: begin
        // Both streams finished and nothing left in the buffer
        if (source_flags_i.done && writer_flags_i.done && fifo_empty_i) begin
          state_d = crypt_pkg::FINISHED;
        end
      end
      crypt_pkg::FINISHED: begin
        state_d = crypt_pkg::IDLE;
      end
      default: begin
        state_d = crypt_pkg::IDLE;
      end
    endcase
  end

  // Outputs decoded from the current state only
  always_comb begin
    engine_ctrl_o       = '0;
    stream_ctrl_o       = '0;
    slave_ctrl_o        = '0;
    engine_ctrl_o.clear = (state_q == crypt_pkg::IDLE);
    stream_ctrl_o.start = (state_q == crypt_pkg::STARTING);
    slave_ctrl_o.done   = (state_q == crypt_pkg::FINISHED);
  end

  assign busy_o = (state_q != crypt_pkg::IDLE);

  finished_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    (state_q == crypt_pkg::FINISHED) |=> (state_q == crypt_pkg::IDLE))
    else $error("FINISHED held for more than one cycle");

endmodule

`default_nettype wire

// File: verilog/crypt_regfile.sv
`default_nettype none

`include "crypt_defs.svh"

module crypt_regfile (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire                       cfg_we_i,
  input  wire [`CRYPT_REG_AW-1:0]   cfg_addr_i,
  input  wire [`CRYPT_DATA_W-1:0]   cfg_wdata_i,
  output logic [`CRYPT_DATA_W-1:0]  cfg_rdata_o,
  input  wire                       busy_i,
  input  wire crypt_pkg::slave_ctrl_t slave_ctrl_i,
  output crypt_pkg::slave_flags_t   slave_flags_o,
  output crypt_pkg::cfg_t           cfg_o
);

  crypt_pkg::cfg_t cfg_q;
  logic            start_q;
  logic            done_q;
  logic            cmd_start;

  // A start already in flight also counts as busy
  assign cmd_start = cfg_we_i && (cfg_addr_i == `CRYPT_REG_CMD) && cfg_wdata_i[0] &&
                     !busy_i && !start_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_q   <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= cmd_start;
      // Sticky done, dropped when the next run starts
      if (start_q) begin
        done_q <= 1'b0;
      end else if (slave_ctrl_i.done) begin
        done_q <= 1'b1;
      end
      if (cfg_we_i) begin
        case (cfg_addr_i)
          `CRYPT_REG_SRC:    cfg_q.src_base  <= cfg_wdata_i[`CRYPT_ADDR_W-1:0];
          `CRYPT_REG_DST:    cfg_q.dst_base  <= cfg_wdata_i[`CRYPT_ADDR_W-1:0];
          `CRYPT_REG_CNT:    cfg_q.blk_count <= cfg_wdata_i[`CRYPT_CNT_W-1:0];
          `CRYPT_REG_KEY_LO: cfg_q.key[`CRYPT_DATA_W-1:0] <= cfg_wdata_i;
          `CRYPT_REG_KEY_HI: cfg_q.key[2*`CRYPT_DATA_W-1:`CRYPT_DATA_W] <= cfg_wdata_i;
          default: ;
        endcase
      end
    end
  end

  // Readback
  always_comb begin
    case (cfg_addr_i)
      `CRYPT_REG_SRC:    cfg_rdata_o = `CRYPT_DATA_W'(cfg_q.src_base);
      `CRYPT_REG_DST:    cfg_rdata_o = `CRYPT_DATA_W'(cfg_q.dst_base);
      `CRYPT_REG_CNT:    cfg_rdata_o = `CRYPT_DATA_W'(cfg_q.blk_count);
      `CRYPT_REG_KEY_LO: cfg_rdata_o = cfg_q.key[`CRYPT_DATA_W-1:0];
      `CRYPT_REG_KEY_HI: cfg_rdata_o = cfg_q.key[2*`CRYPT_DATA_W-1:`CRYPT_DATA_W];
      `CRYPT_REG_STATUS: cfg_rdata_o = `CRYPT_DATA_W'({done_q, busy_i});
      default:           cfg_rdata_o = '0;
    endcase
  end

  assign slave_flags_o.start = start_q;
  assign cfg_o               = cfg_q;

  // The FSM is idle when start arrives and picks it up on the next edge
  start_accepted: assert property (@(posedge clk) disable iff (!reset_n)
    slave_flags_o.start |-> !busy_i ##1 busy_i)
    else $error("start pulse not taken cleanly by the control FSM");

endmodule

`default_nettype wire

// File: verilog/crypt_pkg.sv
`default_nettype none

`include "crypt_defs.svh"

package crypt_pkg;

  typedef enum logic [1:0] {
    IDLE,
    STARTING,
    WORKING,
    FINISHED
  } crypt_state_t;

  // Feistel view, right half sits in the low word
  typedef struct packed {
    logic [`CRYPT_DATA_W-1:0] left;
    logic [`CRYPT_DATA_W-1:0] right;
  } block_halves_t;

  // One 64-bit block, seen as memory words or as Feistel halves
  typedef union packed {
    logic [1:0][`CRYPT_DATA_W-1:0] word;
    block_halves_t                 half;
  } block_u;

  typedef struct packed {
    logic [`CRYPT_ADDR_W-1:0]   src_base;
    logic [`CRYPT_ADDR_W-1:0]   dst_base;
    logic [`CRYPT_CNT_W-1:0]    blk_count;
    logic [2*`CRYPT_DATA_W-1:0] key;
  } cfg_t;

  typedef struct packed {
    logic start;
  } stream_ctrl_t;

  typedef struct packed {
    logic done;
  } source_flags_t;

  typedef struct packed {
    logic done;
  } writer_flags_t;

  typedef struct packed {
    logic clear;
  } engine_ctrl_t;

  typedef struct packed {
    logic start;
  } slave_flags_t;

  typedef struct packed {
    logic done;
  } slave_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/crypt_defs.svh
`ifndef CRYPT_DEFS_SVH
`define CRYPT_DEFS_SVH

// Memory side
`define CRYPT_DATA_W      32
`define CRYPT_ADDR_W      16
`define CRYPT_CNT_W       8

// Datapath sizing
`define CRYPT_FIFO_DEPTH  4
`define CRYPT_ROUNDS      8

// Host register map, word indices
`define CRYPT_REG_AW      3
`define CRYPT_REG_SRC     3'd0
`define CRYPT_REG_DST     3'd1
`define CRYPT_REG_CNT     3'd2
`define CRYPT_REG_KEY_LO  3'd3
`define CRYPT_REG_KEY_HI  3'd4
`define CRYPT_REG_CMD     3'd5
`define CRYPT_REG_STATUS  3'd6

`endif
